// File: src/rv32_pkg.sv
package rv32_pkg;

    // datapath and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // major opcodes still handled, rv32i encodings
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_br    = 7'b1100011
    } opcode_e;

    // alu functions
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    // branch conditions, valued as funct3
    typedef enum logic [2:0] {
        br_beq = 3'b000,
        br_bne = 3'b001,
        br_blt = 3'b100,
        br_bge = 3'b101
    } br_op_e;

    // decoded instruction carried from decode into execute and memory
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        // immediate already extended for its format
        word_t    imm;
        alu_op_e  alu_op;
        // second alu operand from imm instead of rs2
        logic     use_imm;
        br_op_e   br_op;
        logic     reg_write;
    } decoded_t;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    // pipeline bubble, no register write, no memory access
    localparam decoded_t DEC_BUBBLE = '{
        opcode: op_imm, rs1: '0, rs2: '0, rd: '0, imm: '0,
        alu_op: alu_add, use_imm: 1'b1, br_op: br_beq, reg_write: 1'b0
    };

endpackage

// File: src/pipe_ctrl_if.sv
`timescale 1ns/1ps

interface pipe_ctrl_if import rv32_pkg::*; ();

    // memory wait, freezes every pipeline register
    logic  stall;
    // load in execute feeds the instruction in decode
    logic  load_use;
    // taken branch in execute
    logic  flush;
    // branch target
    word_t redirect_pc;

    modport hazard (output stall, output load_use);

    modport exec (output flush, output redirect_pc, input stall);

    modport fetch (input stall, input load_use, input flush, input redirect_pc);

    modport decode (input stall, input load_use, input flush);

endinterface

// File: src/fwd_bus_if.sv
`timescale 1ns/1ps

interface fwd_bus_if import rv32_pkg::*; ();

    // memory stage destination and alu/lui result
    reg_idx_t mem_rd;
    word_t    mem_result;
    // writeback destination, selected data, enable
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     wb_en;

    modport source (output mem_rd, output mem_result, output wb_rd, output wb_data,
                    output wb_en);

    modport sink_ex (input mem_rd, input mem_result, input wb_rd, input wb_data, input wb_en);

    modport sink_rf (input wb_rd, input wb_data, input wb_en);

endinterface

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import rv32_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0060
) (
    input  logic        clk,
    input  logic        arst_n,
    pipe_ctrl_if.fetch  ctrl,
    output logic        inst_read,
    output word_t       inst_addr,
    input  word_t       inst_rdata,
    output word_t       id_instr,
    output word_t       id_pc
);

    word_t pc;
    // goes high on the first edge after reset, fetching starts there
    logic  fetch_en;

    assign inst_read = fetch_en;
    assign inst_addr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_en <= 1'b0;
            pc       <= RESET_PC;
            id_instr <= NOP_INSTR;
            id_pc    <= RESET_PC;
        end else begin
            fetch_en <= 1'b1;
            if (!ctrl.stall) begin
                if (ctrl.flush) begin
                    // squash the instruction being fetched
                    pc       <= ctrl.redirect_pc;
                    id_instr <= NOP_INSTR;
                end else if (!ctrl.load_use) begin
                    // no fetch yet means nothing valid on inst_rdata
                    if (fetch_en) begin
                        pc <= pc + 32'd4;
                    end
                    id_instr <= fetch_en ? inst_rdata : NOP_INSTR;
                    id_pc    <= pc;
                end
            end
        end
    end

endmodule

// File: src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import rv32_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    pipe_ctrl_if.decode ctrl,
    fwd_bus_if.sink_rf  fwd,
    input  word_t       id_instr,
    input  word_t       id_pc,
    output reg_idx_t    id_rs1,
    output reg_idx_t    id_rs2,
    output decoded_t    ex_dec,
    output word_t       ex_rs1_val,
    output word_t       ex_rs2_val,
    output word_t       ex_pc
);

    decoded_t dec;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    regs [32];
    logic [2:0] funct3;

    assign funct3 = id_instr[14:12];

    always_comb begin
        // unknown encodings stay a bubble
        dec = DEC_BUBBLE;
        unique case (id_instr[6:0])
            op_reg, op_imm: begin
                dec.opcode    = (id_instr[6:0] == op_reg) ? op_reg : op_imm;
                dec.rs1       = id_instr[19:15];
                dec.rd        = id_instr[11:7];
                dec.reg_write = 1'b1;
                dec.use_imm   = (id_instr[6:0] == op_imm);
                // i-type imm whose low five bits double as shamt
                dec.imm       = {{20{id_instr[31]}}, id_instr[31:20]};
                if (id_instr[6:0] == op_reg) begin
                    dec.rs2 = id_instr[24:20];
                end
                case (funct3)
                    3'b000: dec.alu_op = (id_instr[6:0] == op_reg && id_instr[30]) ? alu_sub
                                                                                  : alu_add;
                    3'b001: dec.alu_op = alu_sll;
                    3'b010: dec.alu_op = alu_slt;
                    3'b011: dec.alu_op = alu_sltu;
                    3'b100: dec.alu_op = alu_xor;
                    3'b101: dec.alu_op = id_instr[30] ? alu_sra : alu_srl;
                    3'b110: dec.alu_op = alu_or;
                    default: dec.alu_op = alu_and;
                endcase
            end
            op_lui: begin
                dec.opcode    = op_lui;
                dec.rd        = id_instr[11:7];
                dec.reg_write = 1'b1;
                dec.imm       = {id_instr[31:12], 12'd0};
            end
            op_load: begin
                // word loads only
                if (funct3 == 3'b010) begin
                    dec.opcode    = op_load;
                    dec.rs1       = id_instr[19:15];
                    dec.rd        = id_instr[11:7];
                    dec.reg_write = 1'b1;
                    dec.imm       = {{20{id_instr[31]}}, id_instr[31:20]};
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin
                    dec.opcode = op_store;
                    dec.rs1    = id_instr[19:15];
                    dec.rs2    = id_instr[24:20];
                    dec.imm    = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
                end
            end
            op_br: begin
                if (funct3 inside {br_beq, br_bne, br_blt, br_bge}) begin
                    dec.opcode  = op_br;
                    dec.rs1     = id_instr[19:15];
                    dec.rs2     = id_instr[24:20];
                    dec.br_op   = br_op_e'(funct3);
                    dec.imm     = {{19{id_instr[31]}}, id_instr[31], id_instr[7],
                                   id_instr[30:25], id_instr[11:8], 1'b0};
                end
            end
            default: ;
        endcase
    end

    // unused source fields stay zero and raise no false interlock
    assign id_rs1 = dec.rs1;
    assign id_rs2 = dec.rs2;

    // x0 reads zero and a same-cycle writeback is bypassed
    always_comb begin
        rs1_val = regs[dec.rs1];
        rs2_val = regs[dec.rs2];
        if (fwd.wb_en && fwd.wb_rd == dec.rs1) begin
            rs1_val = fwd.wb_data;
        end
        if (fwd.wb_en && fwd.wb_rd == dec.rs2) begin
            rs2_val = fwd.wb_data;
        end
        if (dec.rs1 == '0) begin
            rs1_val = '0;
        end
        if (dec.rs2 == '0) begin
            rs2_val = '0;
        end
    end

    // register file write in writeback
    always_ff @(posedge clk) begin
        if (fwd.wb_en && fwd.wb_rd != '0) begin
            regs[fwd.wb_rd] <= fwd.wb_data;
        end
    end

    // id/ex control takes a bubble on interlock or flush
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_dec <= DEC_BUBBLE;
        end else if (!ctrl.stall) begin
            ex_dec <= (ctrl.load_use || ctrl.flush) ? DEC_BUBBLE : dec;
        end
    end

    // id/ex operands
    always_ff @(posedge clk) begin
        if (!ctrl.stall) begin
            ex_rs1_val <= rs1_val;
            ex_rs2_val <= rs2_val;
            ex_pc      <= id_pc;
        end
    end

endmodule

// File: src/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import rv32_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    pipe_ctrl_if.exec   ctrl,
    fwd_bus_if.sink_ex  fwd,
    input  decoded_t    ex_dec,
    input  word_t       ex_rs1_val,
    input  word_t       ex_rs2_val,
    input  word_t       ex_pc,
    output decoded_t    mem_dec,
    output word_t       mem_alu,
    output word_t       mem_store_data
);

    word_t op_a;
    word_t op_b;
    word_t rs2_fwd;
    word_t alu_res;
    logic  br_taken;

    // memory stage first, then writeback, then register file
    function automatic word_t fwd_pick(reg_idx_t rs, word_t rf_val, reg_idx_t m_rd,
                                       word_t m_val, reg_idx_t w_rd, word_t w_val,
                                       logic w_en);
        word_t val;
        val = rf_val;
        if (rs != '0 && w_en && w_rd == rs) begin
            val = w_val;
        end
        if (rs != '0 && m_rd == rs) begin
            val = m_val;
        end
        return val;
    endfunction

    always_comb begin
        op_a    = fwd_pick(ex_dec.rs1, ex_rs1_val, fwd.mem_rd, fwd.mem_result,
                           fwd.wb_rd, fwd.wb_data, fwd.wb_en);
        rs2_fwd = fwd_pick(ex_dec.rs2, ex_rs2_val, fwd.mem_rd, fwd.mem_result,
                           fwd.wb_rd, fwd.wb_data, fwd.wb_en);
        op_b    = ex_dec.use_imm ? ex_dec.imm : rs2_fwd;
    end

    always_comb begin
        unique case (ex_dec.alu_op)
            alu_sub:  alu_res = op_a - op_b;
            alu_and:  alu_res = op_a & op_b;
            alu_or:   alu_res = op_a | op_b;
            alu_xor:  alu_res = op_a ^ op_b;
            alu_slt:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_res = {31'd0, op_a < op_b};
            alu_sll:  alu_res = op_a << op_b[4:0];
            alu_srl:  alu_res = op_a >> op_b[4:0];
            alu_sra:  alu_res = $signed(op_a) >>> op_b[4:0];
            default:  alu_res = op_a + op_b;
        endcase
        // lui passes the immediate straight through
        if (ex_dec.opcode == op_lui) begin
            alu_res = ex_dec.imm;
        end
    end

    // branch compare on forwarded operands
    always_comb begin
        unique case (ex_dec.br_op)
            br_bne:  br_taken = (op_a != rs2_fwd);
            br_blt:  br_taken = ($signed(op_a) < $signed(rs2_fwd));
            br_bge:  br_taken = ($signed(op_a) >= $signed(rs2_fwd));
            default: br_taken = (op_a == rs2_fwd);
        endcase
    end

    assign ctrl.flush       = (ex_dec.opcode == op_br) && br_taken;
    assign ctrl.redirect_pc = ex_pc + ex_dec.imm;

    // ex/mem control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_dec <= DEC_BUBBLE;
        end else if (!ctrl.stall) begin
            mem_dec <= ctrl.flush ? DEC_BUBBLE : ex_dec;
        end
    end

    // ex/mem payload
    always_ff @(posedge clk) begin
        if (!ctrl.stall) begin
            mem_alu        <= alu_res;
            mem_store_data <= rs2_fwd;
        end
    end

endmodule

// File: src/mem_wb_unit.sv
`timescale 1ns/1ps

module mem_wb_unit import rv32_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        stall,
    fwd_bus_if.source   fwd,
    input  decoded_t    mem_dec,
    input  word_t       mem_alu,
    input  word_t       mem_store_data,
    output logic        data_read,
    output logic        data_write,
    output word_t       data_addr,
    output word_t       data_wdata,
    input  word_t       data_rdata
);

    logic     wb_en_q;
    logic     wb_is_load;
    reg_idx_t wb_rd_q;
    word_t    wb_alu;
    word_t    wb_rdata;

    // request while the instruction sits in ex/mem
    assign data_read  = (mem_dec.opcode == op_load);
    assign data_write = (mem_dec.opcode == op_store);
    assign data_addr  = {mem_alu[XLEN-1:2], 2'b00};
    assign data_wdata = mem_store_data;

    // forwarding source, rd zero when no write
    assign fwd.mem_rd     = mem_dec.reg_write ? mem_dec.rd : '0;
    assign fwd.mem_result = mem_alu;

    // mem/wb control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en_q    <= 1'b0;
            wb_rd_q    <= '0;
            wb_is_load <= 1'b0;
        end else if (!stall) begin
            wb_en_q    <= mem_dec.reg_write && (mem_dec.rd != '0);
            wb_rd_q    <= mem_dec.reg_write ? mem_dec.rd : '0;
            wb_is_load <= data_read;
        end
    end

    // mem/wb payload, load data valid on the completing cycle
    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_alu   <= mem_alu;
            wb_rdata <= data_rdata;
        end
    end

    assign fwd.wb_en   = wb_en_q;
    assign fwd.wb_rd   = wb_rd_q;
    assign fwd.wb_data = wb_is_load ? wb_rdata : wb_alu;

endmodule

// File: src/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import rv32_pkg::*; (
    pipe_ctrl_if.hazard ctrl,
    input  logic        inst_read,
    input  logic        inst_resp,
    input  logic        data_read,
    input  logic        data_write,
    input  logic        data_resp,
    input  reg_idx_t    id_rs1,
    input  reg_idx_t    id_rs2,
    input  decoded_t    ex_dec
);

    logic inst_wait;
    logic data_wait;

    // either port still waiting for its response
    assign inst_wait  = inst_read && !inst_resp;
    assign data_wait  = (data_read || data_write) && !data_resp;
    assign ctrl.stall = inst_wait || data_wait;

    // load result not ready for the next instruction
    assign ctrl.load_use = (ex_dec.opcode == op_load) && (ex_dec.rd != '0) &&
                           ((ex_dec.rd == id_rs1) || (ex_dec.rd == id_rs2));

endmodule

// File: src/rv32_pipeline.sv
`timescale 1ns/1ps

module rv32_pipeline import rv32_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0060
) (
    input  logic  clk,
    input  logic  arst_n,
    output logic  inst_read,
    output word_t inst_addr,
    input  logic  inst_resp,
    input  word_t inst_rdata,
    output logic  data_read,
    output logic  data_write,
    output word_t data_addr,
    output word_t data_wdata,
    input  logic  data_resp,
    input  word_t data_rdata
);

    // stage to stage pipeline registers
    word_t    id_instr;
    word_t    id_pc;
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;
    decoded_t ex_dec;
    word_t    ex_rs1_val;
    word_t    ex_rs2_val;
    word_t    ex_pc;
    decoded_t mem_dec;
    word_t    mem_alu;
    word_t    mem_store_data;

    pipe_ctrl_if ctrl_bus ();
    fwd_bus_if   fwd_bus ();

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_unit_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl_bus.fetch),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .id_instr   (id_instr),
        .id_pc      (id_pc)
    );

    decode_unit decode_unit_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl_bus.decode),
        .fwd        (fwd_bus.sink_rf),
        .id_instr   (id_instr),
        .id_pc      (id_pc),
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .ex_dec     (ex_dec),
        .ex_rs1_val (ex_rs1_val),
        .ex_rs2_val (ex_rs2_val),
        .ex_pc      (ex_pc)
    );

    execute_unit execute_unit_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .ctrl           (ctrl_bus.exec),
        .fwd            (fwd_bus.sink_ex),
        .ex_dec         (ex_dec),
        .ex_rs1_val     (ex_rs1_val),
        .ex_rs2_val     (ex_rs2_val),
        .ex_pc          (ex_pc),
        .mem_dec        (mem_dec),
        .mem_alu        (mem_alu),
        .mem_store_data (mem_store_data)
    );

    mem_wb_unit mem_wb_unit_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .stall          (ctrl_bus.stall),
        .fwd            (fwd_bus.source),
        .mem_dec        (mem_dec),
        .mem_alu        (mem_alu),
        .mem_store_data (mem_store_data),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_rdata     (data_rdata)
    );

    hazard_unit hazard_unit_i (
        .ctrl       (ctrl_bus.hazard),
        .inst_read  (inst_read),
        .inst_resp  (inst_resp),
        .data_read  (data_read),
        .data_write (data_write),
        .data_resp  (data_resp),
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .ex_dec     (ex_dec)
    );

endmodule

// File: bench/rv32_pipeline_tb.sv
`timescale 1ns/1ps

module rv32_pipeline_tb import rv32_pkg::*; ();

    localparam word_t RESET_PC = 32'h0000_0060;
    // store address of the skipped instructions that no table entry expects
    localparam logic [11:0] BAD_ADDR = 12'h3f0;

    logic  clk;
    logic  arst_n;
    logic  inst_read;
    word_t inst_addr;
    logic  inst_resp;
    word_t inst_rdata;
    logic  data_read;
    logic  data_write;
    word_t data_addr;
    word_t data_wdata;
    logic  data_resp;
    word_t data_rdata;

    // program and expected stores in retire order
    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t imem [1024];
    word_t dmem [1024];
    word_t slot_addr;

    integer seed;
    int     err_cnt;
    int     store_cnt;
    int     cycles;
    int     limit;
    logic   timed_out;

    rv32_pipeline #(
        .RESET_PC (RESET_PC)
    ) rv32_pipeline_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_resp  (inst_resp),
        .inst_rdata (inst_rdata),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_resp  (data_resp),
        .data_rdata (data_rdata)
    );

    always #10 clk = ~clk;

    // rv32i encoders
    function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(logic [19:0] imm, reg_idx_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // initial data memory word with the inverted address in the upper half
    function automatic word_t fill_word(word_t addr);
        return {~addr[15:0], addr[15:0]};
    endfunction

    // addi x0 carrying its own byte address executes as a nop
    function automatic word_t nop_word(word_t addr);
        return i_type(addr[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011);
    endfunction

    task automatic emit(word_t instr);
        prog.push_back(instr);
    endtask

    task automatic alu_reg(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                           reg_idx_t rs2);
        emit(r_type(f7, rs2, rs1, f3, rd));
    endtask

    task automatic alu_imm(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        emit(i_type(imm, rs1, f3, rd, 7'b0010011));
    endtask

    task automatic load_word(reg_idx_t rd, logic [11:0] addr);
        emit(i_type(addr, 5'd0, 3'b010, rd, 7'b0000011));
    endtask

    // sw rs to the next result slot and record its expected value
    task automatic store_check(reg_idx_t rs, word_t value);
        emit(s_type(slot_addr[11:0], rs, 5'd0));
        exp_addr.push_back(slot_addr);
        exp_data.push_back(value);
        slot_addr = slot_addr + 32'd4;
    endtask

    // branch over two instructions with stray stores in the shadow of a taken one
    task automatic branch_over(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, logic taken);
        emit(b_type(13'd12, rs2, rs1, f3));
        if (taken) begin
            emit(s_type(BAD_ADDR, 5'd1, 5'd0));
            emit(s_type(BAD_ADDR, 5'd1, 5'd0));
        end
    endtask

    task automatic check_value(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h at store %0d", name, got, exp,
                     store_cnt);
            err_cnt++;
        end
    endtask

    task automatic build_program();
        slot_addr = 32'h0000_0200;
        // the addi after the store takes x1 from writeback
        emit(u_type(20'h12345, 5'd1));
        store_check(1, 32'h1234_5000);
        alu_imm(3'b000, 1, 1, 12'h678);
        store_check(1, 32'h1234_5678);
        alu_imm(3'b000, 2, 0, 12'hf00);
        alu_imm(3'b000, 10, 0, 12'h0f0);
        alu_imm(3'b000, 11, 0, 12'h004);
        // register forms with each result stored at once from the memory stage
        alu_reg(7'h00, 3'b000, 3, 1, 2);
        store_check(3, 32'h1234_5578);
        alu_reg(7'h20, 3'b000, 4, 1, 2);
        store_check(4, 32'h1234_5778);
        alu_reg(7'h00, 3'b111, 5, 1, 2);
        store_check(5, 32'h1234_5600);
        alu_reg(7'h00, 3'b110, 6, 1, 10);
        store_check(6, 32'h1234_56f8);
        alu_reg(7'h00, 3'b100, 7, 1, 2);
        store_check(7, 32'hedcb_a978);
        alu_reg(7'h00, 3'b010, 8, 2, 1);
        store_check(8, 32'h0000_0001);
        alu_reg(7'h00, 3'b011, 9, 2, 1);
        store_check(9, 32'h0000_0000);
        alu_reg(7'h00, 3'b001, 12, 1, 11);
        store_check(12, 32'h2345_6780);
        alu_reg(7'h00, 3'b101, 13, 2, 11);
        store_check(13, 32'h0fff_fff0);
        alu_reg(7'h20, 3'b101, 14, 2, 11);
        store_check(14, 32'hffff_fff0);
        // immediate forms
        alu_imm(3'b111, 15, 1, 12'h0ff);
        store_check(15, 32'h0000_0078);
        alu_imm(3'b110, 16, 1, 12'hff0);
        store_check(16, 32'hffff_fff8);
        alu_imm(3'b100, 17, 1, 12'h7ff);
        store_check(17, 32'h1234_5187);
        alu_imm(3'b010, 18, 2, 12'hf01);
        store_check(18, 32'h0000_0001);
        alu_imm(3'b011, 19, 1, 12'hfff);
        store_check(19, 32'h0000_0001);
        alu_imm(3'b001, 20, 1, 12'h008);
        store_check(20, 32'h3456_7800);
        alu_imm(3'b101, 21, 2, 12'h008);
        store_check(21, 32'h00ff_ffff);
        alu_imm(3'b101, 22, 2, 12'h408);
        store_check(22, 32'hffff_ffff);
        alu_imm(3'b000, 23, 1, 12'h988);
        store_check(23, 32'h1234_5000);
        // add sees x25 from writeback and x26 from memory
        alu_imm(3'b000, 25, 0, 12'h007);
        alu_imm(3'b000, 26, 0, 12'h001);
        alu_reg(7'h00, 3'b000, 27, 25, 26);
        store_check(27, 32'h0000_0008);
        // x0 keeps zero as destination and as source
        alu_imm(3'b000, 0, 0, 12'h005);
        alu_reg(7'h00, 3'b000, 28, 0, 11);
        store_check(0, 32'h0000_0000);
        store_check(28, 32'h0000_0004);
        // load-use through rs1, through rs2, and into a store
        load_word(29, 12'h300);
        alu_imm(3'b000, 30, 29, 12'h001);
        store_check(30, fill_word(32'h300) + 32'd1);
        load_word(29, 12'h304);
        alu_reg(7'h00, 3'b000, 31, 0, 29);
        store_check(31, fill_word(32'h304));
        load_word(5, 12'h308);
        store_check(5, fill_word(32'h308));
        // taken branches
        branch_over(3'b000, 11, 11, 1'b1);
        branch_over(3'b001, 1, 2, 1'b1);
        branch_over(3'b100, 2, 1, 1'b1);
        branch_over(3'b101, 1, 2, 1'b1);
        // not taken ones each guard a store that a wrong redirect would skip
        branch_over(3'b000, 1, 2, 1'b0);
        store_check(11, 32'h0000_0004);
        branch_over(3'b001, 11, 11, 1'b0);
        store_check(2, 32'hffff_ff00);
        branch_over(3'b100, 1, 2, 1'b0);
        store_check(10, 32'h0000_00f0);
        branch_over(3'b101, 2, 1, 1'b0);
        store_check(1, 32'h1234_5678);
    endtask

    // port models drive responses 1 ns after the edge
    initial begin : mem_model
        int   inst_left;
        int   data_left;
        logic inst_busy;
        logic data_busy;
        logic fetch_started;
        inst_resp     = 1'b0;
        inst_rdata    = '0;
        data_resp     = 1'b0;
        data_rdata    = '0;
        inst_busy     = 1'b0;
        data_busy     = 1'b0;
        inst_left     = 0;
        data_left     = 0;
        fetch_started = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = fill_word(i * 4);
        end
        forever begin
            @(negedge clk);
            // request outputs quiet in reset, fetch continuous once started
            if (!arst_n) begin
                check_value("inst_read", inst_read, 1'b0);
                check_value("data_read", data_read, 1'b0);
                check_value("data_write", data_write, 1'b0);
            end else if (fetch_started) begin
                check_value("inst_read", inst_read, 1'b1);
            end else if (inst_read) begin
                check_value("inst_addr", inst_addr, RESET_PC);
            end
            if (arst_n && inst_read) begin
                fetch_started = 1'b1;
            end
            if (arst_n && data_write && data_resp) begin
                dmem[data_addr[11:2]] = data_wdata;
                // retires only when the fetch port is not holding the pipeline
                if (!(inst_read && !inst_resp)) begin
                    if (store_cnt < exp_data.size()) begin
                        check_value("data_addr", data_addr, exp_addr[store_cnt]);
                        check_value("data_wdata", data_wdata, exp_data[store_cnt]);
                    end else begin
                        $display("store to %h arrived after the last expected store",
                                 data_addr);
                        err_cnt++;
                    end
                    store_cnt++;
                end
            end
            @(posedge clk);
            #1;
            if (inst_read) begin
                if (!inst_busy) begin
                    inst_busy = 1'b1;
                    inst_left = $unsigned($random(seed)) % 3;
                end
                if (inst_left == 0) begin
                    inst_resp  = 1'b1;
                    inst_rdata = imem[inst_addr[11:2]];
                    inst_busy  = 1'b0;
                end else begin
                    inst_resp = 1'b0;
                    inst_left = inst_left - 1;
                end
            end else begin
                inst_resp = 1'b0;
            end
            if (data_read || data_write) begin
                if (!data_busy) begin
                    data_busy = 1'b1;
                    data_left = $unsigned($random(seed)) % 3;
                end
                if (data_left == 0) begin
                    data_resp  = 1'b1;
                    data_rdata = dmem[data_addr[11:2]];
                    data_busy  = 1'b0;
                end else begin
                    data_resp = 1'b0;
                    data_left = data_left - 1;
                end
            end else begin
                data_resp = 1'b0;
            end
        end
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        seed      = 25607;
        err_cnt   = 0;
        store_cnt = 0;
        cycles    = 0;
        timed_out = 1'b0;
        build_program();
        // unused instruction words execute as nops
        for (int i = 0; i < 1024; i++) begin
            imem[i] = nop_word(i * 4);
        end
        foreach (prog[i]) begin
            imem[RESET_PC[11:2] + i] = prog[i];
        end
        limit = exp_data.size() * prog.size() * 4;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        while (store_cnt < exp_data.size() && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (store_cnt < exp_data.size()) begin
            $display("timeout: stores missing");
            timed_out = 1'b1;
        end else begin
            // a squashed store that leaked would show up in this drain
            repeat (20) @(posedge clk);
        end
        $display("stores: %0d of %0d, errors: %0d, cycles: %0d", store_cnt,
                 exp_data.size(), err_cnt, cycles);
        if (err_cnt == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: rv32_pipeline.f
src/rv32_pkg.sv
src/pipe_ctrl_if.sv
src/fwd_bus_if.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/mem_wb_unit.sv
src/hazard_unit.sv
src/rv32_pipeline.sv
bench/rv32_pipeline_tb.sv

// File: Bender.yml
package:
  name: rv32_pipeline

sources:
  - src/rv32_pkg.sv
  - src/pipe_ctrl_if.sv
  - src/fwd_bus_if.sv
  - src/fetch_unit.sv
  - src/decode_unit.sv
  - src/execute_unit.sv
  - src/mem_wb_unit.sv
  - src/hazard_unit.sv
  - src/rv32_pipeline.sv
  - target: simulation
    files:
      - bench/rv32_pipeline_tb.sv
